// ==== Makefile ====
# Verilator build and run of the instruction fetch testbench

VERILATOR ?= verilator
TOP       ?= tb_instr_fetch
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@if grep -q "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/fetch_pkg.sv ====
/* shared widths, depths, vector typedefs, aligner state enum and the
   packed structs passed between the instruction fetch stages */

package fetch_pkg;

  // prefetch buffer depth in 32-bit words
  localparam int BUF_DEPTH   = 4;
  // instruction memory answers a request this many cycles later, always
  localparam int MEM_LATENCY = 1;

  // byte address or program counter
  typedef logic [31:0] addr_t;
  // one instruction memory word
  typedef logic [31:0] word_t;
  // one 16-bit instruction parcel
  typedef logic [15:0] half_t;
  // buffer occupancy, 0 up to BUF_DEPTH plus headroom for the in-flight sum
  typedef logic [2:0]  buf_cnt_t;

  // aligner states, where the next instruction starts
  typedef enum logic [2:0] {
    ALIGNED32,
    ALIGNED16,
    MISALIGNED32,
    MISALIGNED16,
    WAIT_MIS16,
    BRANCH_MIS
  } align_state_e;

  // head of the prefetch buffer as seen by the aligner
  typedef struct packed {
    logic  valid;
    word_t word;
  } fetch_word_s;

  // instruction handed to the decode stage
  // compressed parcels are zero-extended, flag set
  typedef struct packed {
    word_t instr;
    logic  compressed;
    addr_t pc;
  } instr_out_s;

endpackage

// ==== rtl/fetch_requester.sv ====
/* fetch requester, issues word reads to instruction memory while the
   prefetch buffer has room and restarts at a branch target */

`timescale 1ns/100ps

module fetch_requester (
  input  logic                clk,
  input  logic                rst_n,

  // redirect from the pipeline
  input  logic                branch_i,
  input  fetch_pkg::addr_t    branch_addr_i,

  // current prefetch buffer occupancy
  input  fetch_pkg::buf_cnt_t buf_cnt_i,

  // instruction memory request port
  output logic                mem_req_o,
  output fetch_pkg::addr_t    mem_addr_o
);

  import fetch_pkg::*;

  // next word address to read
  addr_t    addr_q;
  // requests issued but not yet written into the buffer
  buf_cnt_t inflight_q;
  // words that will sit in the buffer once all responses are in
  buf_cnt_t occupancy;
  // low during reset and the first cycle after it
  logic     active_q;

  ////////////////////////////////////////////////////////////////////////////
  // request decision
  ////////////////////////////////////////////////////////////////////////////

  // reserve a slot for every outstanding request
  // so a response never finds the buffer full
  assign occupancy  = buf_cnt_i + inflight_q;
  assign mem_req_o  = active_q && (occupancy < buf_cnt_t'(BUF_DEPTH));
  assign mem_addr_o = addr_q;

  ////////////////////////////////////////////////////////////////////////////
  // address and in-flight tracking
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q     <= '0;
      inflight_q <= '0;
      active_q   <= 1'b0;
    end else begin
      active_q <= 1'b1;

      // one-cycle memory: only last cycle's request can be outstanding
      // a request in the branch cycle is dropped by the buffer, not counted
      if (branch_i) begin
        inflight_q <= '0;
      end else if (mem_req_o) begin
        inflight_q <= buf_cnt_t'(1);
      end else begin
        inflight_q <= '0;
      end

      // restart on the word that holds the target
      // sequential words follow
      if (branch_i) begin
        addr_q <= {branch_addr_i[31:2], 2'b00};
      end else if (mem_req_o) begin
        addr_q <= addr_q + 32'd4;
      end
    end
  end

endmodule

// ==== rtl/instr_aligner.sv ====
/* instruction aligner, FSM that cuts buffered words into 16/32-bit
   instructions, joins split 32-bit ones and tracks the pc */

`timescale 1ns/100ps

module instr_aligner (
  input  logic                   clk,
  input  logic                   rst_n,

  // prefetch buffer head and its control
  input  fetch_pkg::fetch_word_s head_i,
  output logic                   pop_o,
  output logic                   hold_o,

  // decode stage
  input  logic                   id_ready_i,
  input  logic                   flush_i,

  // redirect
  input  logic                   branch_i,
  input  fetch_pkg::addr_t       branch_addr_i,

  output fetch_pkg::instr_out_s  instr_o,
  output logic                   instr_valid_o
);

  import fetch_pkg::*;

  align_state_e state_q;
  align_state_e state_n;
  addr_t        pc_q;
  addr_t        pc_n;
  addr_t        pc_plus2;
  addr_t        pc_plus4;

  // upper half of the last consumed word
  half_t        r_half_q;
  half_t        lo_half;
  half_t        hi_half;

  word_t        instr_word;
  logic         instr_cmp;
  logic         instr_vld;

  // registers take state_n, pc_n and the upper half
  logic         update;
  // decode takes the instruction, or a flush lets it go
  logic         advance;

  assign lo_half  = head_i.word[15:0];
  assign hi_half  = head_i.word[31:16];
  assign pc_plus2 = pc_q + 32'd2;
  assign pc_plus4 = pc_q + 32'd4;
  assign advance  = id_ready_i || flush_i;

  ////////////////////////////////////////////////////////////////////////////
  // next state and output decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_n    = state_q;
    pc_n       = pc_q;
    instr_word = head_i.word;
    instr_cmp  = 1'b0;
    instr_vld  = head_i.valid;
    hold_o     = 1'b0;
    update     = 1'b0;

    case (state_q)
      // instruction starts at the low half of the head word
      // MISALIGNED16 finds the head word kept there by hold
      ALIGNED32, MISALIGNED16, WAIT_MIS16: begin
        if (lo_half[1:0] == 2'b11) begin
          // full aligned 32-bit word
          state_n = ALIGNED32;
          pc_n    = pc_plus4;
        end else begin
          // compressed, next one starts in the upper half
          state_n    = ALIGNED16;
          pc_n       = pc_plus2;
          instr_word = {16'h0000, lo_half};
          instr_cmp  = 1'b1;
        end
        update = head_i.valid && advance;
      end

      // instruction starts at the stored upper half
      ALIGNED16, MISALIGNED32: begin
        if (r_half_q[1:0] == 2'b11) begin
          // 32-bit split over two words, low half comes from the head
          state_n    = MISALIGNED32;
          pc_n       = pc_plus4;
          instr_word = {lo_half, r_half_q};
          update     = head_i.valid && advance;
        end else begin
          // compressed in the stored half
          // the head word is still whole, keep it in the buffer
          pc_n       = pc_plus2;
          instr_word = {16'h0000, r_half_q};
          instr_cmp  = 1'b1;
          hold_o     = head_i.valid;
          if (state_q == ALIGNED16) begin
            state_n = MISALIGNED16;
            update  = head_i.valid && advance;
          end else begin
            // stored half is complete on its own
            // no head word needed
            instr_vld = 1'b1;
            state_n   = head_i.valid ? MISALIGNED16 : WAIT_MIS16;
            update    = advance;
          end
        end
      end

      // target sits in the upper half of the head word
      BRANCH_MIS: begin
        if (hi_half[1:0] == 2'b11) begin
          // misaligned 32-bit target
          // store the upper half and wait for the next word
          state_n   = MISALIGNED32;
          instr_vld = 1'b0;
          update    = head_i.valid;
        end else begin
          state_n    = ALIGNED32;
          pc_n       = pc_plus2;
          instr_word = {16'h0000, hi_half};
          instr_cmp  = 1'b1;
          update     = head_i.valid && advance;
        end
      end

      default: begin
        // unused encodings fall back to the word boundary
        state_n   = ALIGNED32;
        instr_vld = 1'b0;
        update    = 1'b1;
      end
    endcase

    // redirect overrides everything above
    if (branch_i) begin
      pc_n    = branch_addr_i;
      state_n = branch_addr_i[1] ? BRANCH_MIS : ALIGNED32;
      update  = 1'b1;
    end
  end

  // the head leaves the buffer when consumed, unless hold keeps it
  assign pop_o         = update && head_i.valid;
  assign instr_valid_o = instr_vld && !branch_i;
  assign instr_o       = '{instr: instr_word, compressed: instr_cmp, pc: pc_q};

  ////////////////////////////////////////////////////////////////////////////
  // state, pc and stored half
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ALIGNED32;
      pc_q    <= '0;
    end else if (update) begin
      state_q <= state_n;
      pc_q    <= pc_n;
    end
  end

  always_ff @(posedge clk) begin
    if (update) begin
      r_half_q <= hi_half;
    end
  end

endmodule

// ==== rtl/instr_fetch_top.sv ====
/* instruction fetch front end, requester, prefetch buffer and aligner */

`timescale 1ns/100ps

module instr_fetch_top (
  input  logic                  clk,
  input  logic                  rst_n,

  // instruction memory, fixed one-cycle read latency
  output logic                  mem_req_o,
  output fetch_pkg::addr_t      mem_addr_o,
  input  logic                  mem_rvalid_i,
  input  fetch_pkg::word_t      mem_rdata_i,

  // decode stage
  input  logic                  id_ready_i,
  input  logic                  flush_i,

  // redirect, one-cycle pulse to all stages
  input  logic                  branch_i,
  input  fetch_pkg::addr_t      branch_addr_i,

  output fetch_pkg::instr_out_s instr_o,
  output logic                  instr_valid_o
);

  import fetch_pkg::*;

  // buffer level back to the requester
  buf_cnt_t    buf_cnt;
  // head word and consume control between buffer and aligner
  fetch_word_s head;
  logic        pop;
  logic        hold;

  fetch_requester u_requester (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .buf_cnt_i     (buf_cnt),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o)
  );

  prefetch_buffer u_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .branch_i     (branch_i),
    .pop_i        (pop),
    .hold_i       (hold),
    .head_o       (head),
    .cnt_o        (buf_cnt)
  );

  instr_aligner u_aligner (
    .clk           (clk),
    .rst_n         (rst_n),
    .head_i        (head),
    .pop_o         (pop),
    .hold_o        (hold),
    .id_ready_i    (id_ready_i),
    .flush_i       (flush_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .instr_o       (instr_o),
    .instr_valid_o (instr_valid_o)
  );

endmodule

// ==== rtl/prefetch_buffer.sv ====
/* prefetch buffer, circular FIFO of returned instruction words that
   flushes on a branch and discards the stale response behind it */

`timescale 1ns/100ps

module prefetch_buffer (
  input  logic                  clk,
  input  logic                  rst_n,

  // memory response
  input  logic                  mem_rvalid_i,
  input  fetch_pkg::word_t      mem_rdata_i,

  // redirect, empties the FIFO
  input  logic                  branch_i,

  // aligner side
  input  logic                  pop_i,
  input  logic                  hold_i,
  output fetch_pkg::fetch_word_s head_o,
  output fetch_pkg::buf_cnt_t   cnt_o
);

  import fetch_pkg::*;

  // word storage, payload only
  word_t mem_q [BUF_DEPTH];

  logic [$clog2(BUF_DEPTH)-1:0]     wr_ptr_q;
  logic [$clog2(BUF_DEPTH)-1:0]     rd_ptr_q;
  buf_cnt_t                         cnt_q;

  // counts down the cycles in which a pre-branch response can still arrive
  logic [$clog2(MEM_LATENCY+1)-1:0] drop_cnt_q;
  logic                             drop;

  logic                             wr_en;
  logic                             rd_en;

  assign drop  = (drop_cnt_q != '0);

  // branch wins over both sides
  // a response in the branch cycle is stale too
  assign wr_en = mem_rvalid_i && !drop && !branch_i;
  // hold keeps the head for a second compressed instruction
  assign rd_en = pop_i && !hold_i && (cnt_q != '0) && !branch_i;

  assign head_o = '{valid: (cnt_q != '0), word: mem_q[rd_ptr_q]};
  assign cnt_o  = cnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // pointers, count and stale-response filter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      cnt_q      <= '0;
      drop_cnt_q <= '0;
    end else begin
      if (branch_i) begin
        wr_ptr_q   <= '0;
        rd_ptr_q   <= '0;
        cnt_q      <= '0;
        // requests issued up to the branch cycle come back later
        drop_cnt_q <= $bits(drop_cnt_q)'(MEM_LATENCY);
      end else begin
        if (wr_en) begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
        if (rd_en) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
        cnt_q <= cnt_q + buf_cnt_t'(wr_en) - buf_cnt_t'(rd_en);
        if (drop) begin
          drop_cnt_q <= drop_cnt_q - 1'b1;
        end
      end
    end
  end

  // data write, visible at the head next cycle
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= mem_rdata_i;
    end
  end

endmodule

// ==== test/tb_imem_model.sv ====
/* instruction memory model, one-cycle read latency, image written by the
   testbench before reset is released */

`timescale 1ns/100ps

module tb_imem_model (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             req_i,
  input  fetch_pkg::addr_t addr_i,
  output logic             rvalid_o,
  output fetch_pkg::word_t rdata_o
);

  import fetch_pkg::*;

  localparam int MEM_WORDS = 1024;

  // word storage, indexed by the word address
  word_t mem_q [MEM_WORDS];

  // every request is answered in the next cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

  // addresses past the top wrap around
  always_ff @(posedge clk) begin
    if (req_i) begin
      rdata_o <= mem_q[addr_i[11:2]];
    end
  end

endmodule

// ==== test/tb_instr_fetch.sv ====
/* testbench for the instruction fetch front end, LFSR image and reference
   walk, decode-stage stimulus, watchdog and concurrent checks */

`timescale 1ns/100ps

module tb_instr_fetch;

  import fetch_pkg::*;

  localparam int          RESET_CYCLES = 10;
  localparam int          MEM_WORDS    = 1024;
  localparam int          IMG_HALVES   = 2 * MEM_WORDS;
  localparam logic [31:0] LFSR_SEED    = 32'h4b4bb4d8;
  localparam logic [31:0] LFSR_TAPS    = 32'h80200003;
  // kinds of the first image instructions
  // bit n is set when instruction n is 32-bit
  // four aligned 32-bit, five compressed, two misaligned 32-bit
  localparam logic [11:0] FORCED_KINDS = 12'h60f;
  localparam int          TOTAL_INSTR  = 1 + 40 + 3 * 10 + 150 + 150;

  logic        clk;
  logic        rst_n;
  logic        mem_req;
  addr_t       mem_addr;
  logic        mem_rvalid;
  word_t       mem_rdata;
  logic        id_ready;
  logic        flush;
  logic        branch;
  addr_t       branch_addr;
  instr_out_s  instr;
  logic        instr_valid;

  // parcel view of the memory image
  half_t       image [IMG_HALVES];
  logic [31:0] lfsr_q;
  // reference walk state
  // exp_q holds what decode must see this cycle
  addr_t       model_pc;
  instr_out_s  exp_q;
  logic        taken;
  int          accepted;
  string       test_name;
  // word that holds the target of last cycle's branch
  addr_t       branch_word_q;

  instr_fetch_top UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .mem_req_o     (mem_req),
    .mem_addr_o    (mem_addr),
    .mem_rvalid_i  (mem_rvalid),
    .mem_rdata_i   (mem_rdata),
    .id_ready_i    (id_ready),
    .flush_i       (flush),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .instr_o       (instr),
    .instr_valid_o (instr_valid)
  );

  tb_imem_model imem (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (mem_req),
    .addr_i   (mem_addr),
    .rvalid_o (mem_rvalid),
    .rdata_o  (mem_rdata)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r      = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return r;
  endfunction

  // decode the parcel at pc by its low bits as the ISA defines
  function automatic instr_out_s expected_at(input addr_t pc);
    half_t      lo;
    half_t      hi;
    instr_out_s e;
    lo   = image[pc[11:1]];
    hi   = image[pc[11:1] + 11'd1];
    e.pc = pc;
    if (lo[1:0] == 2'b11) begin
      e.instr      = {hi, lo};
      e.compressed = 1'b0;
    end else begin
      e.instr      = {16'h0000, lo};
      e.compressed = 1'b1;
    end
    return e;
  endfunction

  function automatic string fmt_instr(input instr_out_s v);
    return $sformatf("instr %h c %0b pc %h", v.instr, v.compressed, v.pc);
  endfunction

  // first odd parcel from start whose kind matches
  function automatic addr_t find_target(input int start, input logic want32);
    int i;
    i = start | 1;
    while ((i < IMG_HALVES - 64) && ((image[i][1:0] == 2'b11) != want32)) begin
      i += 2;
    end
    return addr_t'(i) << 1;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic build_image();
    int          idx;
    int          n;
    logic        is32;
    logic [31:0] w;
    idx = 0;
    n   = 0;
    while (idx < IMG_HALVES) begin
      if (n < 12) begin
        is32 = FORCED_KINDS[n[3:0]];
      end else begin
        is32 = (rand_bits(1) != 0);
      end
      if (is32 && (idx < IMG_HALVES - 1)) begin
        w              = rand_bits(30);
        image[idx]     = {w[13:0], 2'b11};
        image[idx + 1] = w[29:14];
        idx += 2;
      end else begin
        // compressed, low bits anything but 11
        w          = rand_bits(16);
        image[idx] = {w[15:2], (w[1:0] == 2'b11) ? 2'b10 : w[1:0]};
        idx += 1;
      end
      n++;
    end
    for (idx = 0; idx < MEM_WORDS; idx++) begin
      imem.mem_q[idx] = {image[2 * idx + 1], image[2 * idx]};
    end
  endtask

  // one clock that retires last cycle's instruction, drives, then samples mid-cycle
  task automatic step_cycle(input logic ready, input logic br, input addr_t br_addr);
    @(posedge clk);
    #2;
    if (taken) begin
      model_pc = model_pc + (exp_q.compressed ? 32'd2 : 32'd4);
    end
    if (br) begin
      model_pc = br_addr;
    end
    exp_q       = expected_at(model_pc);
    id_ready    = ready;
    branch      = br;
    branch_addr = br_addr;
    @(negedge clk);
    taken = instr_valid && id_ready;
    if (taken) begin
      accepted++;
    end
  endtask

  // mode 0 always ready, 1 random stalls, 2 random stalls and branches
  task automatic run_instrs(input string name, input int count, input int mode);
    int    target;
    logic  ready;
    logic  br;
    addr_t br_addr;
    test_name = name;
    target    = accepted + count;
    while (accepted < target) begin
      ready   = 1'b1;
      br      = 1'b0;
      br_addr = '0;
      if (mode > 0) begin
        ready = (rand_bits(1) != 0);
      end
      if ((mode > 1) && (rand_bits(4) == 0)) begin
        br      = 1'b1;
        br_addr = rand_bits(10) << 1;
      end
      step_cycle(ready, br, br_addr);
    end
  endtask

  task automatic branch_to(input string name, input addr_t target);
    test_name = name;
    step_cycle(1'b1, 1'b1, target);
    run_instrs(name, 10, 0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // bits 1 and 0 of the target cleared
  always @(posedge clk) begin
    branch_word_q <= {branch_addr[31:2], 2'b00};
  end

  reset_quiet: assert property (@(posedge clk) !rst_n |-> (!instr_valid && !mem_req))
    else report_failure($sformatf("ERR %s: expected valid 0 req 0, actual valid %0b req %0b",
                                  test_name, $sampled(instr_valid), $sampled(mem_req)));

  // the cycle after a branch reads the word that holds the target
  branch_request: assert property (@(posedge clk) disable iff (!rst_n)
      branch |=> (mem_req && (mem_addr == branch_word_q)))
    else report_failure($sformatf("ERR %s: expected req 1 addr %h, actual req %0b addr %h",
                                  test_name, $sampled(branch_word_q), $sampled(mem_req),
                                  $sampled(mem_addr)));

  // every accepted instruction is the next one of the reference walk
  accept_match: assert property (@(posedge clk) disable iff (!rst_n)
      (instr_valid && id_ready) |-> (instr == exp_q))
    else report_failure($sformatf("ERR %s: expected %s, actual %s", test_name,
                                  fmt_instr(exp_q), fmt_instr($sampled(instr))));

  // a stalled instruction waits unchanged unless a branch drops it
  stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (instr_valid && !id_ready) |=> (branch || (instr_valid && $stable(instr))))
    else report_failure($sformatf("ERR %s: expected held %s, actual %s", test_name,
                                  fmt_instr(exp_q), fmt_instr($sampled(instr))));

  ////////////////////////////////////////////////////////////////////////////
  // clock, watchdog, sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (RESET_CYCLES + TOTAL_INSTR * 20) @(posedge clk);
    report_failure("watchdog expired, the instruction stream stopped making progress");
  end

  initial begin
    rst_n       = 1'b0;
    id_ready    = 1'b0;
    flush       = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    lfsr_q      = LFSR_SEED;
    taken       = 1'b0;
    accepted    = 0;
    model_pc    = '0;
    test_name   = "reset";
    build_image();
    exp_q = expected_at(model_pc);
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    run_instrs("reset", 1, 0);
    run_instrs("sequential", 40, 0);
    branch_to("branch_aligned", 32'h0000_0100);
    branch_to("branch_mis16", find_target(300, 1'b0));
    branch_to("branch_mis32", find_target(400, 1'b1));
    run_instrs("backpressure", 150, 1);
    run_instrs("random_branch", 150, 2);
    // let the last accepted instruction reach its check
    @(posedge clk);
    #2;
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== vlog.f ====
rtl/fetch_pkg.sv
rtl/fetch_requester.sv
rtl/prefetch_buffer.sv
rtl/instr_aligner.sv
rtl/instr_fetch_top.sv
test/tb_imem_model.sv
test/tb_instr_fetch.sv
